// ==== Bender.yml ====
package:
  name: pad_control

sources:
  - files:
      - common/pad_pkg.sv
      - rtl/pad_drive_mux.sv
      - rtl/pad_sense_demux.sv
      - rtl/pad_control_top.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_pad_control.sv

// ==== common/pad_pkg.sv ====
`default_nettype none

package pad_pkg;

	localparam int NUM_PADS = 11;

	// pad indices, also the bit order of every per-pad vector.
	localparam int PAD_SPIM_SDIO0 = 0;
	localparam int PAD_SPIM_SDIO1 = 1;
	localparam int PAD_SPIM_SDIO2 = 2;
	localparam int PAD_SPIM_SDIO3 = 3;
	localparam int PAD_SPIM_CSN0  = 4;
	localparam int PAD_SPIM_CSN1  = 5;
	localparam int PAD_SPIM_SCK   = 6;
	localparam int PAD_UART_RX    = 7;
	localparam int PAD_UART_TX    = 8;
	localparam int PAD_I2C0_SDA   = 9;
	localparam int PAD_I2C0_SCL   = 10;

	// function select of a single pad.
	typedef enum logic [1:0] {
		FUNC_PERIPH = 2'b00, // pad's own peripheral.
		FUNC_GPIO   = 2'b01,
		FUNC_ALT    = 2'b10, // i2c1, on four pads only.
		FUNC_NONE   = 2'b11
	} pad_func_e;

	// two bits per pad, pad 0 in the lowest bits.
	typedef pad_func_e [NUM_PADS-1:0] pad_mux_t;

	// spi master towards the pads.
	typedef struct packed {
		logic [3:0] sdo;
		logic [3:0] oen; // active low.
		logic [1:0] csn;
		logic       sck;
	} spim_out_t;

	// spi master from the pads.
	typedef struct packed {
		logic [3:0] sdi;
	} spim_in_t;

	// i2c controller towards the pads.
	typedef struct packed {
		logic scl_out;
		logic scl_oe;
		logic sda_out;
		logic sda_oe;
	} i2c_out_t;

	// i2c controller from the pads.
	typedef struct packed {
		logic scl_in;
		logic sda_in;
	} i2c_in_t;

	// gpio controller, one bit per pad.
	typedef struct packed {
		logic [NUM_PADS-1:0] out;
		logic [NUM_PADS-1:0] dir; // 1 drives the pad.
	} gpio_out_t;

	// what goes to the pad cells.
	typedef struct packed {
		logic [NUM_PADS-1:0] out;
		logic [NUM_PADS-1:0] oe;
	} pad_drive_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+testbench
common/pad_pkg.sv
rtl/pad_drive_mux.sv
rtl/pad_sense_demux.sv
rtl/pad_control_top.sv
testbench/tb_pad_control.sv

// ==== rtl/pad_control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_control_top #(
	parameter int PAD_CFG_W = 6
) (
	// spi master.
	input  pad_pkg::spim_out_t                            spim_i,
	output pad_pkg::spim_in_t                             spim_o,

	// uart.
	input  logic                                          uart_tx_i,
	output logic                                          uart_rx_o,

	// i2c controllers, i2c1 only reachable as alternate function.
	input  pad_pkg::i2c_out_t                             i2c0_i,
	output pad_pkg::i2c_in_t                              i2c0_o,
	input  pad_pkg::i2c_out_t                             i2c1_i,
	output pad_pkg::i2c_in_t                              i2c1_o,

	// gpio controller.
	input  pad_pkg::gpio_out_t                            gpio_i,
	output logic [pad_pkg::NUM_PADS-1:0]                  gpio_in_o,
	input  logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0]        gpio_cfg_i,

	// pad side.
	input  pad_pkg::pad_mux_t                             pad_mux_i,
	input  logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0]        pad_cfg_i,
	output logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0]        pad_cfg_o,
	input  logic [pad_pkg::NUM_PADS-1:0]                  pad_in_i,
	output pad_pkg::pad_drive_t                           pad_o
);

	// outbound: values, enables and pad configuration.
	pad_drive_mux #(
		.PAD_CFG_W (PAD_CFG_W)
	) i_pad_drive_mux (
		.pad_mux_i  (pad_mux_i),
		.spim_i     (spim_i),
		.uart_tx_i  (uart_tx_i),
		.i2c0_i     (i2c0_i),
		.i2c1_i     (i2c1_i),
		.gpio_i     (gpio_i),
		.pad_cfg_i  (pad_cfg_i),
		.gpio_cfg_i (gpio_cfg_i),
		.pad_o      (pad_o),
		.pad_cfg_o  (pad_cfg_o)
	);

	// inbound: pad levels back to whoever owns the pad.
	pad_sense_demux i_pad_sense_demux (
		.pad_mux_i (pad_mux_i),
		.pad_in_i  (pad_in_i),
		.spim_o    (spim_o),
		.uart_rx_o (uart_rx_o),
		.i2c0_o    (i2c0_o),
		.i2c1_o    (i2c1_o),
		.gpio_in_o (gpio_in_o)
	);

endmodule

`default_nettype wire

// ==== rtl/pad_drive_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_drive_mux #(
	parameter int PAD_CFG_W = 6
) (
	input  pad_pkg::pad_mux_t                      pad_mux_i,
	input  pad_pkg::spim_out_t                     spim_i,
	input  logic                                   uart_tx_i,
	input  pad_pkg::i2c_out_t                      i2c0_i,
	input  pad_pkg::i2c_out_t                      i2c1_i,
	input  pad_pkg::gpio_out_t                     gpio_i,
	input  logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0] pad_cfg_i,
	input  logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0] gpio_cfg_i,
	output pad_pkg::pad_drive_t                    pad_o,
	output logic [pad_pkg::NUM_PADS*PAD_CFG_W-1:0] pad_cfg_o
);

	import pad_pkg::*;

	// candidate drive per function with one bit per pad.
	logic [NUM_PADS-1:0] periph_out;
	logic [NUM_PADS-1:0] periph_oe;
	logic [NUM_PADS-1:0] alt_out;
	logic [NUM_PADS-1:0] alt_oe;
	logic [NUM_PADS-1:0] drv_out;
	logic [NUM_PADS-1:0] drv_oe;

	// peripheral function of every pad.
	always_comb begin
		periph_out = '0;
		periph_oe  = '0;

		for (int i = 0; i < $bits(spim_i.sdo); i++) begin
			periph_out[PAD_SPIM_SDIO0 + i] = spim_i.sdo[i];
			periph_oe[PAD_SPIM_SDIO0 + i]  = ~spim_i.oen[i]; // oen is active low.
		end

		periph_out[PAD_SPIM_CSN0] = spim_i.csn[0];
		periph_oe[PAD_SPIM_CSN0]  = 1'b1;
		periph_out[PAD_SPIM_CSN1] = spim_i.csn[1];
		periph_oe[PAD_SPIM_CSN1]  = 1'b1;
		periph_out[PAD_SPIM_SCK]  = spim_i.sck;
		periph_oe[PAD_SPIM_SCK]   = 1'b1;

		// uart rx pad is input only and left at 0.
		periph_out[PAD_UART_TX] = uart_tx_i;
		periph_oe[PAD_UART_TX]  = 1'b1;

		periph_out[PAD_I2C0_SDA] = i2c0_i.sda_out; // open drain via oe.
		periph_oe[PAD_I2C0_SDA]  = i2c0_i.sda_oe;
		periph_out[PAD_I2C0_SCL] = i2c0_i.scl_out;
		periph_oe[PAD_I2C0_SCL]  = i2c0_i.scl_oe;
	end

	// i2c1 as alternate function on two pad pairs.
	always_comb begin
		alt_out = '0;
		alt_oe  = '0;

		alt_out[PAD_SPIM_SDIO2] = i2c1_i.sda_out;
		alt_oe[PAD_SPIM_SDIO2]  = i2c1_i.sda_oe;
		alt_out[PAD_SPIM_SDIO3] = i2c1_i.scl_out;
		alt_oe[PAD_SPIM_SDIO3]  = i2c1_i.scl_oe;

		alt_out[PAD_UART_RX] = i2c1_i.sda_out;
		alt_oe[PAD_UART_RX]  = i2c1_i.sda_oe;
		alt_out[PAD_UART_TX] = i2c1_i.scl_out;
		alt_oe[PAD_UART_TX]  = i2c1_i.scl_oe;
	end

	// per-pad selection.
	always_comb begin
		for (int p = 0; p < NUM_PADS; p++) begin
			case (pad_mux_i[p])
				FUNC_PERIPH: begin
					drv_out[p] = periph_out[p];
					drv_oe[p]  = periph_oe[p];
				end
				FUNC_GPIO: begin
					drv_out[p] = gpio_i.out[p];
					drv_oe[p]  = gpio_i.dir[p];
				end
				FUNC_ALT: begin
					drv_out[p] = alt_out[p];
					drv_oe[p]  = alt_oe[p];
				end
				default: begin
					drv_out[p] = 1'b0; // pad floats under FUNC_NONE.
					drv_oe[p]  = 1'b0;
				end
			endcase
		end
	end

	assign pad_o = '{out: drv_out, oe: drv_oe};

	// gpio configuration wins while gpio owns the pad.
	for (genvar p = 0; p < NUM_PADS; p++) begin : g_cfg
		assign pad_cfg_o[p*PAD_CFG_W +: PAD_CFG_W] = (pad_mux_i[p] == FUNC_GPIO) ?
			gpio_cfg_i[p*PAD_CFG_W +: PAD_CFG_W] : pad_cfg_i[p*PAD_CFG_W +: PAD_CFG_W];
	end

endmodule

`default_nettype wire

// ==== rtl/pad_sense_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_sense_demux (
	input  pad_pkg::pad_mux_t             pad_mux_i,
	input  logic [pad_pkg::NUM_PADS-1:0]  pad_in_i,
	output pad_pkg::spim_in_t             spim_o,
	output logic                          uart_rx_o,
	output pad_pkg::i2c_in_t              i2c0_o,
	output pad_pkg::i2c_in_t              i2c1_o,
	output logic [pad_pkg::NUM_PADS-1:0]  gpio_in_o
);

	import pad_pkg::*;

	// decoded function per pad.
	logic [NUM_PADS-1:0] is_periph;
	logic [NUM_PADS-1:0] is_gpio;
	logic [NUM_PADS-1:0] is_alt;
	logic [3:0]          sdi;
	logic                i2c1_sda;
	logic                i2c1_scl;

	always_comb begin
		for (int p = 0; p < NUM_PADS; p++) begin
			is_periph[p] = (pad_mux_i[p] == FUNC_PERIPH);
			is_gpio[p]   = (pad_mux_i[p] == FUNC_GPIO);
			is_alt[p]    = (pad_mux_i[p] == FUNC_ALT);
		end
	end

	// gpio sees only the pads it owns.
	assign gpio_in_o = pad_in_i & is_gpio;

	// spi data in, 0 when the sdio pad belongs to someone else.
	always_comb begin
		for (int i = 0; i < $bits(sdi); i++) begin
			sdi[i] = pad_in_i[PAD_SPIM_SDIO0 + i] & is_periph[PAD_SPIM_SDIO0 + i];
		end
	end

	assign spim_o = '{sdi: sdi};

	// uart and i2c idle high when not connected.
	assign uart_rx_o = is_periph[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : 1'b1;

	assign i2c0_o = '{
		scl_in: is_periph[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1,
		sda_in: is_periph[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1
	};

	// spim pads take priority over the uart pads.
	always_comb begin
		if (is_alt[PAD_SPIM_SDIO2]) begin
			i2c1_sda = pad_in_i[PAD_SPIM_SDIO2];
		end else if (is_alt[PAD_UART_RX]) begin
			i2c1_sda = pad_in_i[PAD_UART_RX];
		end else begin
			i2c1_sda = 1'b1;
		end
	end

	always_comb begin
		if (is_alt[PAD_SPIM_SDIO3]) begin
			i2c1_scl = pad_in_i[PAD_SPIM_SDIO3];
		end else if (is_alt[PAD_UART_TX]) begin
			i2c1_scl = pad_in_i[PAD_UART_TX];
		end else begin
			i2c1_scl = 1'b1;
		end
	end

	assign i2c1_o = '{scl_in: i2c1_scl, sda_in: i2c1_sda};

endmodule

`default_nettype wire

// ==== testbench/pad_table.svh ====
`ifndef PAD_TABLE_SVH
`define PAD_TABLE_SVH

// one stimulus vector.
// mux holds two bits per pad with pad 0 lowest.
typedef struct packed {
	logic [2*NUM_PADS-1:0] mux;
	logic [10:0]           spim;    // sdo, oen, csn, sck.
	logic                  uart_tx;
	logic [3:0]            i2c0;    // scl_out, scl_oe, sda_out, sda_oe.
	logic [3:0]            i2c1;
	logic [2*NUM_PADS-1:0] gpio;    // out, dir.
	logic [NUM_PADS-1:0]   pad_in;
} stim_t;

// cfg_sel marks pads whose configuration comes from gpio.
typedef struct packed {
	logic [NUM_PADS-1:0] out;
	logic [NUM_PADS-1:0] oe;
	logic [3:0]          sdi;
	logic                uart_rx;
	logic [1:0]          i2c0;      // scl_in, sda_in.
	logic [1:0]          i2c1;
	logic [NUM_PADS-1:0] gpio_in;
	logic [NUM_PADS-1:0] cfg_sel;
} expect_t;

typedef struct packed {
	stim_t   stim;
	expect_t resp;
} entry_t;

localparam int NUM_ENTRIES = 6;

entry_t dir_table [NUM_ENTRIES];

// columns: mux, spim, uart_tx, i2c0, i2c1, gpio, pad_in
// then out, oe, sdi, uart_rx, i2c0 in, i2c1 in, gpio_in, cfg_sel
task automatic load_table();
	// every pad on its own peripheral.
	dir_table[0] = '{
		'{{11{2'b00}}, 11'b1010_0011_101, 1'b1, 4'b1001, 4'b1111,
			{11'h555, 11'h2aa}, 11'h5a6},
		'{11'h56a, 11'h37c, 4'h6, 1'b1, 2'b10, 2'b11, 11'h000, 11'h000}
	};
	// every pad owned by gpio.
	dir_table[1] = '{
		'{{11{2'b01}}, 11'b1111_0000_111, 1'b1, 4'b1111, 4'b1111,
			{11'h6b3, 11'h4cd}, 11'h2d9},
		'{11'h6b3, 11'h4cd, 4'h0, 1'b1, 2'b11, 2'b11, 11'h2d9, 11'h7ff}
	};
	// i2c1 on spim_sdio2/3, rest unused.
	dir_table[2] = '{
		'{{{7{2'b11}}, {2{2'b10}}, {2{2'b11}}}, 11'b1111_0000_111, 1'b1, 4'b1111, 4'b1101,
			{11'h7ff, 11'h7ff}, 11'h088},
		'{11'h008, 11'h00c, 4'h0, 1'b1, 2'b11, 2'b10, 11'h000, 11'h000}
	};
	// i2c1 on uart_rx/tx.
	dir_table[3] = '{
		'{{{2{2'b11}}, {2{2'b10}}, {7{2'b11}}}, 11'b1111_0000_111, 1'b1, 4'b1111, 4'b0110,
			{11'h7ff, 11'h7ff}, 11'h104},
		'{11'h080, 11'h100, 4'h0, 1'b1, 2'b11, 2'b10, 11'h000, 11'h000}
	};
	// all pads alternate, spim pads win the i2c1 read.
	dir_table[4] = '{
		'{{11{2'b10}}, 11'b1111_0000_111, 1'b1, 4'b1111, 4'b1111,
			{11'h7ff, 11'h7ff}, 11'h6fb},
		'{11'h18c, 11'h18c, 4'h0, 1'b1, 2'b11, 2'b10, 11'h000, 11'h000}
	};
	// nothing drives any pad.
	dir_table[5] = '{
		'{{11{2'b11}}, 11'b1111_0000_111, 1'b1, 4'b1111, 4'b1111,
			{11'h7ff, 11'h7ff}, 11'h7ff},
		'{11'h000, 11'h000, 4'h0, 1'b1, 2'b11, 2'b11, 11'h000, 11'h000}
	};
endtask

`endif

// ==== testbench/tb_pad_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pad_control;

	import pad_pkg::*;

	localparam int CFG_W      = 6;
	localparam int CFG_BITS   = NUM_PADS * CFG_W;
	localparam int NUM_RANDOM = 200;

	`include "pad_table.svh"

	localparam int MAX_CYCLES = 16 + NUM_ENTRIES + NUM_RANDOM + 50;

	logic                clk_i;
	logic                reset_i;
	pad_mux_t            pad_mux;
	spim_out_t           spim;
	spim_in_t            spim_in;
	logic                uart_tx;
	logic                uart_rx;
	i2c_out_t            i2c0_out;
	i2c_in_t             i2c0_in;
	i2c_out_t            i2c1_out;
	i2c_in_t             i2c1_in;
	gpio_out_t           gpio;
	logic [NUM_PADS-1:0] gpio_in;
	logic [CFG_BITS-1:0] gpio_cfg;
	logic [CFG_BITS-1:0] pad_cfg;
	logic [CFG_BITS-1:0] pad_cfg_out;
	logic [NUM_PADS-1:0] pad_in;
	pad_drive_t          pad_drv;

	integer seed   = 32'hb28a_5f6f;
	int     cycles = 0;
	int     checks;
	int     errors;

	initial begin
		clk_i = 1'b0;
		forever begin
			#50 clk_i = ~clk_i;
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run still busy after %0d clock cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	pad_control_top #(
		.PAD_CFG_W (CFG_W)
	) UUT (
		.spim_i     (spim),
		.spim_o     (spim_in),
		.uart_tx_i  (uart_tx),
		.uart_rx_o  (uart_rx),
		.i2c0_i     (i2c0_out),
		.i2c0_o     (i2c0_in),
		.i2c1_i     (i2c1_out),
		.i2c1_o     (i2c1_in),
		.gpio_i     (gpio),
		.gpio_in_o  (gpio_in),
		.gpio_cfg_i (gpio_cfg),
		.pad_mux_i  (pad_mux),
		.pad_cfg_i  (pad_cfg),
		.pad_cfg_o  (pad_cfg_out),
		.pad_in_i   (pad_in),
		.pad_o      (pad_drv)
	);

	// expected response worked out pad by pad.
	function automatic expect_t ref_model(input stim_t s);
		expect_t    e;
		spim_out_t  sp;
		i2c_out_t   i0;
		i2c_out_t   i1;
		gpio_out_t  g;
		logic [1:0] f;
		sp = s.spim;
		i0 = s.i2c0;
		i1 = s.i2c1;
		g  = s.gpio;
		e  = '0;
		e.uart_rx = 1'b1; // idle levels.
		e.i2c0    = 2'b11;
		e.i2c1    = 2'b11;
		for (int p = 0; p < NUM_PADS; p++) begin
			f = s.mux[2*p +: 2];
			if (f == FUNC_GPIO) begin
				e.out[p]     = g.out[p];
				e.oe[p]      = g.dir[p];
				e.gpio_in[p] = s.pad_in[p];
				e.cfg_sel[p] = 1'b1;
			end else if (f == FUNC_PERIPH) begin
				case (p)
					PAD_SPIM_SDIO0, PAD_SPIM_SDIO1, PAD_SPIM_SDIO2, PAD_SPIM_SDIO3: begin
						e.out[p] = sp.sdo[p - PAD_SPIM_SDIO0];
						e.oe[p]  = ~sp.oen[p - PAD_SPIM_SDIO0];
						e.sdi[p - PAD_SPIM_SDIO0] = s.pad_in[p];
					end
					PAD_SPIM_CSN0: {e.out[p], e.oe[p]} = {sp.csn[0], 1'b1};
					PAD_SPIM_CSN1: {e.out[p], e.oe[p]} = {sp.csn[1], 1'b1};
					PAD_SPIM_SCK:  {e.out[p], e.oe[p]} = {sp.sck, 1'b1};
					PAD_UART_RX:   e.uart_rx = s.pad_in[p]; // input only.
					PAD_UART_TX:   {e.out[p], e.oe[p]} = {s.uart_tx, 1'b1};
					PAD_I2C0_SDA: begin
						{e.out[p], e.oe[p]} = {i0.sda_out, i0.sda_oe};
						e.i2c0[0] = s.pad_in[p];
					end
					PAD_I2C0_SCL: begin
						{e.out[p], e.oe[p]} = {i0.scl_out, i0.scl_oe};
						e.i2c0[1] = s.pad_in[p];
					end
					default: ;
				endcase
			end else if (f == FUNC_ALT) begin
				case (p)
					PAD_SPIM_SDIO2, PAD_UART_RX: {e.out[p], e.oe[p]} = {i1.sda_out, i1.sda_oe};
					PAD_SPIM_SDIO3, PAD_UART_TX: {e.out[p], e.oe[p]} = {i1.scl_out, i1.scl_oe};
					default: ;
				endcase
			end
		end
		// spim pad has priority over the uart pad.
		if (s.mux[2*PAD_SPIM_SDIO2 +: 2] == FUNC_ALT) begin
			e.i2c1[0] = s.pad_in[PAD_SPIM_SDIO2];
		end else if (s.mux[2*PAD_UART_RX +: 2] == FUNC_ALT) begin
			e.i2c1[0] = s.pad_in[PAD_UART_RX];
		end
		if (s.mux[2*PAD_SPIM_SDIO3 +: 2] == FUNC_ALT) begin
			e.i2c1[1] = s.pad_in[PAD_SPIM_SDIO3];
		end else if (s.mux[2*PAD_UART_TX +: 2] == FUNC_ALT) begin
			e.i2c1[1] = s.pad_in[PAD_UART_TX];
		end
		return e;
	endfunction

	function automatic logic [CFG_BITS-1:0] exp_cfg(input logic [NUM_PADS-1:0] sel);
		logic [CFG_BITS-1:0] c;
		for (int p = 0; p < NUM_PADS; p++) begin
			c[p*CFG_W +: CFG_W] = sel[p] ? gpio_cfg[p*CFG_W +: CFG_W]
				: pad_cfg[p*CFG_W +: CFG_W];
		end
		return c;
	endfunction

	task automatic check_field(input string label, input string what,
			input logic [127:0] got, input logic [127:0] want);
		checks++;
		assert (got === want) else begin
			$display("[FAIL] %0t: %s %s is %0h, expected %0h", $time, label, what, got, want);
			errors++;
		end
	endtask

	task automatic check_outputs(input string label, input expect_t e);
		check_field(label, "pad out", 128'(pad_drv.out), 128'(e.out));
		check_field(label, "pad oe", 128'(pad_drv.oe), 128'(e.oe));
		check_field(label, "spim sdi", 128'(spim_in), 128'(e.sdi));
		check_field(label, "uart rx", 128'(uart_rx), 128'(e.uart_rx));
		check_field(label, "i2c0 in", 128'(i2c0_in), 128'(e.i2c0));
		check_field(label, "i2c1 in", 128'(i2c1_in), 128'(e.i2c1));
		check_field(label, "gpio in", 128'(gpio_in), 128'(e.gpio_in));
		check_field(label, "pad cfg", 128'(pad_cfg_out), 128'(exp_cfg(e.cfg_sel)));
	endtask

	task automatic apply_stim(input stim_t s);
		pad_mux_t m;
		for (int p = 0; p < NUM_PADS; p++) begin
			m[p] = pad_func_e'(s.mux[2*p +: 2]);
		end
		pad_mux  <= m;
		spim     <= s.spim;
		uart_tx  <= s.uart_tx;
		i2c0_out <= s.i2c0;
		i2c1_out <= s.i2c1;
		gpio     <= s.gpio;
		pad_in   <= s.pad_in;
	endtask

	task automatic random_stim(output stim_t s, output logic [CFG_BITS-1:0] pc,
			output logic [CFG_BITS-1:0] gc);
		logic [95:0] r;
		logic [31:0] w;
		r = {$random(seed), $random(seed), $random(seed)};
		s = r[$bits(stim_t)-1:0];
		for (int p = 0; p < NUM_PADS; p++) begin
			w = $random(seed);
			pc[p*CFG_W +: CFG_W] = w[CFG_W-1:0];
			w = $random(seed);
			gc[p*CFG_W +: CFG_W] = w[CFG_W-1:0];
		end
	endtask

	initial begin
		stim_t               s;
		expect_t             e;
		logic [CFG_BITS-1:0] pc;
		logic [CFG_BITS-1:0] gc;
		int                  tests_run;
		int                  tests_failed;
		int                  err_start;

		$timeformat(-9, 0, " ns", 0);
		tests_run    = 0;
		tests_failed = 0;
		checks       = 0;
		errors       = 0;
		reset_i      = 1'b1;
		for (int p = 0; p < NUM_PADS; p++) begin
			pad_mux[p] = FUNC_PERIPH;
		end
		spim     = '0;
		uart_tx  = 1'b0;
		i2c0_out = '0;
		i2c1_out = '0;
		gpio     = '0;
		gpio_cfg = '0;
		pad_cfg  = '0;
		pad_in   = '0;
		load_table();

		repeat (16) @(posedge clk_i);
		reset_i <= 1'b0;

		// distinct per-pad cfg so the gpio override shows.
		for (int p = 0; p < NUM_PADS; p++) begin
			pc[p*CFG_W +: CFG_W] = CFG_W'(p + 'h20);
			gc[p*CFG_W +: CFG_W] = CFG_W'(p + 'h11);
		end

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			err_start = errors;
			@(posedge clk_i);
			apply_stim(dir_table[i].stim);
			pad_cfg  <= pc;
			gpio_cfg <= gc;
			@(negedge clk_i);
			check_outputs($sformatf("entry %0d", i), dir_table[i].resp);
			tests_run++;
			if (errors != err_start) begin
				tests_failed++;
			end
			$display("entry %0d done, %0d mismatches", i, errors - err_start);
		end

		err_start = errors;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_stim(s, pc, gc);
			e = ref_model(s);
			@(posedge clk_i);
			apply_stim(s);
			pad_cfg  <= pc;
			gpio_cfg <= gc;
			@(negedge clk_i);
			check_outputs($sformatf("random %0d", i), e);
		end
		tests_run++;
		if (errors != err_start) begin
			tests_failed++;
		end
		$display("random phase done, %0d vectors, %0d mismatches", NUM_RANDOM, errors - err_start);

		$display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
